// ==== flist.f ====
verilog/arp_pkg.sv
verilog/arp_entry_store.sv
verilog/arp_resolver.sv
verilog/arp_table.sv
verif/tb_arp_table.sv

// ==== Makefile ====
# Verilator build for the ARP table testbench.

VERILATOR ?= verilator
TOP       ?= tb_arp_table
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The run passes only when the log holds the pass message on a line of its own.
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_arp_table.sv ====
`timescale 1ns/1ps

module tb_arp_table;

localparam int CLK_PERIOD = 8;
localparam int WAIT_LIMIT = 1000;
localparam int K_RSP_VAL  = 0;
localparam int K_RSP_ERR  = 1;
localparam int K_ARP_REQ  = 2;

logic                clk;
logic                rst_n;
logic                arp_in_val;
arp_pkg::ipv4_addr_t arp_in_ipv4_addr;
arp_pkg::mac_addr_t  arp_in_mac_addr;
logic                req;
arp_pkg::ipv4_addr_t req_ipv4_addr;
logic                rsp_val;
arp_pkg::mac_addr_t  rsp_mac_addr;
logic                rsp_err;
logic                arp_req;
arp_pkg::ipv4_addr_t arp_req_ipv4_addr;

integer seed;
int     errors;
int     test_errors;
int     tests_passed;
int     tests_failed;
int     rsp_val_cnt;
int     rsp_err_cnt;
int     arp_req_cnt;

arp_pkg::mac_addr_t  last_rsp_mac;
arp_pkg::ipv4_addr_t last_req_addr;

// Reference table.
arp_pkg::ipv4_addr_t model_ip    [arp_pkg::ARP_TABLE_SIZE];
arp_pkg::mac_addr_t  model_mac   [arp_pkg::ARP_TABLE_SIZE];
bit                  model_valid [arp_pkg::ARP_TABLE_SIZE];
int                  model_ptr;
arp_pkg::ipv4_addr_t known_q     [$];
arp_pkg::ipv4_addr_t distinct_q  [$];

// Two bindings repeat, so their slots are rewritten.
arp_pkg::ipv4_addr_t learn_ip [7] = '{32'hC0A80001, 32'hC0A80002, 32'hC0A80003,
	32'hC0A80002, 32'hC0A80004, 32'hC0A80001, 32'hC0A80005};

arp_table UUT (
	.clk               (clk),
	.rst_n             (rst_n),
	.arp_in_val        (arp_in_val),
	.arp_in_ipv4_addr  (arp_in_ipv4_addr),
	.arp_in_mac_addr   (arp_in_mac_addr),
	.req               (req),
	.req_ipv4_addr     (req_ipv4_addr),
	.rsp_val           (rsp_val),
	.rsp_mac_addr      (rsp_mac_addr),
	.rsp_err           (rsp_err),
	.arp_req           (arp_req),
	.arp_req_ipv4_addr (arp_req_ipv4_addr)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

// Outputs are stable at the falling edge.
always @(negedge clk) begin
	if (rst_n) begin
		if (rsp_val) begin
			rsp_val_cnt++;
			last_rsp_mac = rsp_mac_addr;
		end
		if (rsp_err) begin
			rsp_err_cnt++;
		end
		if (arp_req) begin
			arp_req_cnt++;
			last_req_addr = arp_req_ipv4_addr;
		end
	end
end

function automatic void model_learn(input arp_pkg::ipv4_addr_t ip, input arp_pkg::mac_addr_t m);
	int hit_idx;
	hit_idx = -1;
	for (int i = 0; i < arp_pkg::ARP_TABLE_SIZE; i++) begin
		if (model_valid[i] && model_ip[i] == ip) begin
			hit_idx = i;
		end
	end
	if (hit_idx >= 0) begin
		model_mac[hit_idx] = m;
	end else begin
		model_ip[model_ptr]    = ip;
		model_mac[model_ptr]   = m;
		model_valid[model_ptr] = 1'b1;
		model_ptr = (model_ptr + 1) % arp_pkg::ARP_TABLE_SIZE;
	end
	if (!(ip inside {known_q})) begin
		known_q.push_back(ip);
	end
endfunction

function automatic logic model_lookup(input arp_pkg::ipv4_addr_t ip,
	output arp_pkg::mac_addr_t m);
	model_lookup = 1'b0;
	m = '0;
	for (int i = 0; i < arp_pkg::ARP_TABLE_SIZE; i++) begin
		if (model_valid[i] && model_ip[i] == ip) begin
			model_lookup = 1'b1;
			m = model_mac[i];
		end
	end
endfunction

function automatic arp_pkg::mac_addr_t random_mac();
	logic [63:0] r;
	r = {$random(seed), $random(seed)};
	return r[47:0];
endfunction

function automatic int event_count(input int kind);
	case (kind)
		K_RSP_VAL: return rsp_val_cnt;
		K_RSP_ERR: return rsp_err_cnt;
		default:   return arp_req_cnt;
	endcase
endfunction

task automatic check_value(input string name, input logic [63:0] expected,
	input logic [63:0] actual);
	if (expected !== actual) begin
		$display("ERROR at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		errors++;
	end
endtask

task automatic wait_event(input int kind, input int target, input string name);
	bit ok;
	int cycles;
	ok = 1'b0;
	cycles = 0;
	while (!ok && cycles < WAIT_LIMIT) begin
		@(posedge clk);
		cycles++;
		ok = (event_count(kind) >= target);
	end
	if (!ok) begin
		$display("Timed out after %0d cycles waiting for %s at %0t", WAIT_LIMIT, name, $time);
		errors++;
	end
endtask

task automatic drive_reply(input arp_pkg::ipv4_addr_t ip, input arp_pkg::mac_addr_t m);
	@(negedge clk);
	arp_in_val       = 1'b1;
	arp_in_ipv4_addr = ip;
	arp_in_mac_addr  = m;
	@(negedge clk);
	arp_in_val = 1'b0;
	model_learn(ip, m);
endtask

task automatic send_req(input arp_pkg::ipv4_addr_t ip);
	@(negedge clk);
	req           = 1'b1;
	req_ipv4_addr = ip;
	@(negedge clk);
	req = 1'b0;
endtask

// A hit must answer at once, a miss must request, retry and fail.
task automatic do_lookup(input arp_pkg::ipv4_addr_t ip);
	arp_pkg::mac_addr_t exp_mac;
	logic               exp_hit;
	int                 val_base;
	int                 err_base;
	int                 req_base;
	exp_hit  = model_lookup(ip, exp_mac);
	val_base = rsp_val_cnt;
	err_base = rsp_err_cnt;
	req_base = arp_req_cnt;
	send_req(ip);
	if (exp_hit) begin
		wait_event(K_RSP_VAL, val_base + 1, "rsp_val");
		check_value("rsp_mac_addr", 64'(exp_mac), 64'(last_rsp_mac));
		check_value("arp_req count", 64'(0), 64'(arp_req_cnt - req_base));
	end else begin
		wait_event(K_ARP_REQ, req_base + 1, "arp_req");
		check_value("arp_req_ipv4_addr", 64'(ip), 64'(last_req_addr));
		wait_event(K_RSP_ERR, err_base + 1, "rsp_err");
		check_value("arp_req count", 64'(arp_pkg::ARP_RETRIES + 1),
			64'(arp_req_cnt - req_base));
		check_value("rsp_val count", 64'(0), 64'(rsp_val_cnt - val_base));
	end
endtask

task automatic finish_test(input int num, input string name);
	if (errors == test_errors) begin
		tests_passed++;
		$display("Test %0d %s: passed", num, name);
	end else begin
		tests_failed++;
		$display("Test %0d %s: failed with %0d errors", num, name, errors - test_errors);
	end
	test_errors = errors;
endtask

initial begin
	arp_pkg::ipv4_addr_t addr;
	arp_pkg::mac_addr_t  mac;
	arp_pkg::ipv4_addr_t tmp;
	int                  j;
	int                  val_base;
	int                  err_base;
	int                  req_base;
	seed = 64;
	rst_n = 1'b0;
	arp_in_val = 1'b0;
	arp_in_ipv4_addr = '0;
	arp_in_mac_addr = '0;
	req = 1'b0;
	req_ipv4_addr = '0;
	errors = 0;
	test_errors = 0;
	tests_passed = 0;
	tests_failed = 0;
	rsp_val_cnt = 0;
	rsp_err_cnt = 0;
	arp_req_cnt = 0;
	model_ptr = 0;
	for (int i = 0; i < arp_pkg::ARP_TABLE_SIZE; i++) begin
		model_valid[i] = 1'b0;
	end
	repeat (3) @(negedge clk);
	rst_n = 1'b1;

	repeat (20) @(negedge clk);
	check_value("rsp_val count", 64'(0), 64'(rsp_val_cnt));
	check_value("rsp_err count", 64'(0), 64'(rsp_err_cnt));
	check_value("arp_req count", 64'(0), 64'(arp_req_cnt));
	finish_test(1, "idle after reset");

	for (int i = 0; i < 7; i++) begin
		drive_reply(learn_ip[i], random_mac());
		if (!(learn_ip[i] inside {distinct_q})) begin
			distinct_q.push_back(learn_ip[i]);
		end
	end
	for (int i = distinct_q.size() - 1; i > 0; i--) begin
		j = int'($unsigned($random(seed)) % (i + 1));
		tmp = distinct_q[i];
		distinct_q[i] = distinct_q[j];
		distinct_q[j] = tmp;
	end
	foreach (distinct_q[i]) begin
		do_lookup(distinct_q[i]);
	end
	finish_test(2, "learn and lookup");

	addr = 32'h0A000009;
	val_base = rsp_val_cnt;
	req_base = arp_req_cnt;
	send_req(addr);
	wait_event(K_ARP_REQ, req_base + 1, "arp_req");
	check_value("arp_req_ipv4_addr", 64'(addr), 64'(last_req_addr));
	mac = random_mac();
	drive_reply(addr, mac);
	wait_event(K_RSP_VAL, val_base + 1, "rsp_val");
	check_value("rsp_mac_addr", 64'(mac), 64'(last_rsp_mac));
	do_lookup(addr);
	check_value("arp_req count", 64'(1), 64'(arp_req_cnt - req_base));
	finish_test(3, "miss with reply");

	do_lookup(32'h0A000064);
	finish_test(4, "miss without reply");

	for (int i = 0; i < 4; i++) begin
		drive_reply(32'hAC100001 + 32'(i), random_mac());
	end
	foreach (known_q[i]) begin
		do_lookup(known_q[i]);
	end
	finish_test(5, "pointer wrap and eviction");

	addr = 32'h0A000065;
	val_base = rsp_val_cnt;
	err_base = rsp_err_cnt;
	req_base = arp_req_cnt;
	send_req(addr);
	wait_event(K_ARP_REQ, req_base + 1, "arp_req");
	// A known address, so an accepted request would answer at once.
	send_req(learn_ip[2]);
	wait_event(K_RSP_ERR, err_base + 1, "rsp_err");
	repeat (5) @(negedge clk);
	check_value("arp_req count", 64'(arp_pkg::ARP_RETRIES + 1), 64'(arp_req_cnt - req_base));
	check_value("rsp_val count", 64'(0), 64'(rsp_val_cnt - val_base));
	check_value("rsp_err count", 64'(1), 64'(rsp_err_cnt - err_base));
	check_value("arp_req_ipv4_addr", 64'(addr), 64'(last_req_addr));
	finish_test(6, "request while busy");

	$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
	if (tests_failed == 0 && errors == 0) begin
		$display("Test OK");
	end else begin
		$display("Test FAILED");
	end
	$finish;
end

endmodule

// ==== verilog/arp_table.sv ====
`timescale 1ns/1ps

module arp_table (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                arp_in_val,
	input  arp_pkg::ipv4_addr_t arp_in_ipv4_addr,
	input  arp_pkg::mac_addr_t  arp_in_mac_addr,
	input  logic                req,
	input  arp_pkg::ipv4_addr_t req_ipv4_addr,
	output logic                rsp_val,
	output arp_pkg::mac_addr_t  rsp_mac_addr,
	output logic                rsp_err,
	output logic                arp_req,
	output arp_pkg::ipv4_addr_t arp_req_ipv4_addr
);

arp_pkg::ipv4_addr_t lk_ipv4_addr;
arp_pkg::mac_addr_t  lk_mac_addr;
logic                lk_hit;

// Every received binding is learned, pending or not.
arp_entry_store u_store (
	.clk          (clk),
	.rst_n        (rst_n),
	.wr_val       (arp_in_val),
	.wr_ipv4_addr (arp_in_ipv4_addr),
	.wr_mac_addr  (arp_in_mac_addr),
	.lk_ipv4_addr (lk_ipv4_addr),
	.lk_hit       (lk_hit),
	.lk_mac_addr  (lk_mac_addr)
);

arp_resolver u_resolver (
	.clk               (clk),
	.rst_n             (rst_n),
	.req               (req),
	.req_ipv4_addr     (req_ipv4_addr),
	.arp_in_val        (arp_in_val),
	.arp_in_ipv4_addr  (arp_in_ipv4_addr),
	.arp_in_mac_addr   (arp_in_mac_addr),
	.lk_ipv4_addr      (lk_ipv4_addr),
	.lk_hit            (lk_hit),
	.lk_mac_addr       (lk_mac_addr),
	.rsp_val           (rsp_val),
	.rsp_mac_addr      (rsp_mac_addr),
	.rsp_err           (rsp_err),
	.arp_req           (arp_req),
	.arp_req_ipv4_addr (arp_req_ipv4_addr)
);

endmodule

// ==== verilog/arp_resolver.sv ====
`timescale 1ns/1ps

module arp_resolver (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                req,
	input  arp_pkg::ipv4_addr_t req_ipv4_addr,
	input  logic                arp_in_val,
	input  arp_pkg::ipv4_addr_t arp_in_ipv4_addr,
	input  arp_pkg::mac_addr_t  arp_in_mac_addr,
	output arp_pkg::ipv4_addr_t lk_ipv4_addr,
	input  logic                lk_hit,
	input  arp_pkg::mac_addr_t  lk_mac_addr,
	output logic                rsp_val,
	output arp_pkg::mac_addr_t  rsp_mac_addr,
	output logic                rsp_err,
	output logic                arp_req,
	output arp_pkg::ipv4_addr_t arp_req_ipv4_addr
);

typedef enum logic [1:0] {
	ST_IDLE,
	ST_CHECK,
	ST_WAIT
} state_t;

state_t state;

arp_pkg::ipv4_addr_t pend_ipv4_addr;

logic [arp_pkg::ARP_TIMER_W-1:0] tmr;
logic [arp_pkg::ARP_RETRY_W-1:0] retry_cnt;

logic reply_match;
logic timeout;
logic retry_left;

assign lk_ipv4_addr = pend_ipv4_addr;

assign reply_match = arp_in_val && (arp_in_ipv4_addr == pend_ipv4_addr);
assign timeout     = (tmr == arp_pkg::ARP_TIMER_W'(arp_pkg::ARP_TIMEOUT_TICKS - 1));
assign retry_left  = (retry_cnt < arp_pkg::ARP_RETRY_W'(arp_pkg::ARP_RETRIES));

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		state     <= ST_IDLE;
		tmr       <= '0;
		retry_cnt <= '0;
		rsp_val   <= 1'b0;
		rsp_err   <= 1'b0;
		arp_req   <= 1'b0;
	end else begin
		// Output strobes last one cycle.
		rsp_val <= 1'b0;
		rsp_err <= 1'b0;
		arp_req <= 1'b0;
		case (state)
			ST_IDLE: begin
				if (req) begin
					state <= ST_CHECK;
				end
			end
			ST_CHECK: begin
				if (lk_hit) begin
					rsp_val <= 1'b1;
					state   <= ST_IDLE;
				end else begin
					arp_req   <= 1'b1;
					tmr       <= '0;
					retry_cnt <= '0;
					state     <= ST_WAIT;
				end
			end
			ST_WAIT: begin
				if (reply_match) begin
					rsp_val <= 1'b1;
					state   <= ST_IDLE;
				end else if (timeout) begin
					tmr <= '0;
					if (retry_left) begin
						arp_req   <= 1'b1;
						retry_cnt <= retry_cnt + 1'b1;
					end else begin
						rsp_err <= 1'b1;
						state   <= ST_IDLE;
					end
				end else begin
					tmr <= tmr + 1'b1;
				end
			end
			default: begin
				state <= ST_IDLE;
			end
		endcase
	end
end

// Pending address is taken only from an accepted request.
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		pend_ipv4_addr <= '0;
	end else if (state == ST_IDLE && req) begin
		pend_ipv4_addr <= req_ipv4_addr;
	end
end

// Answer comes from the table on a hit and from the reply while waiting.
always_ff @(posedge clk) begin
	if (state == ST_CHECK && lk_hit) begin
		rsp_mac_addr <= lk_mac_addr;
	end else if (state == ST_WAIT && reply_match) begin
		rsp_mac_addr <= arp_in_mac_addr;
	end
end

always_ff @(posedge clk) begin
	if (state == ST_CHECK && !lk_hit) begin
		arp_req_ipv4_addr <= pend_ipv4_addr;
	end
end

assert property (@(posedge clk) disable iff (!rst_n) !(rsp_val && rsp_err))
	else $error("arp_resolver: rsp_val and rsp_err raised together");

// Requests are always spaced by at least one timeout period.
assert property (@(posedge clk) disable iff (!rst_n) arp_req |=> !arp_req)
	else $error("arp_resolver: arp_req pulsed in consecutive cycles");

endmodule

// ==== verilog/arp_entry_store.sv ====
`timescale 1ns/1ps

module arp_entry_store (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                wr_val,
	input  arp_pkg::ipv4_addr_t wr_ipv4_addr,
	input  arp_pkg::mac_addr_t  wr_mac_addr,
	input  arp_pkg::ipv4_addr_t lk_ipv4_addr,
	output logic                lk_hit,
	output arp_pkg::mac_addr_t  lk_mac_addr
);

logic [arp_pkg::ARP_TABLE_SIZE-1:0] valid;
logic [arp_pkg::ARP_IDX_W-1:0]      ins_ptr;

arp_pkg::ipv4_addr_t ipv4_mem [arp_pkg::ARP_TABLE_SIZE];
arp_pkg::mac_addr_t  mac_mem  [arp_pkg::ARP_TABLE_SIZE];

logic [arp_pkg::ARP_TABLE_SIZE-1:0] wr_match;
logic [arp_pkg::ARP_TABLE_SIZE-1:0] lk_match;
logic [arp_pkg::ARP_TABLE_SIZE-1:0] wr_sel;
logic                               wr_hit;

// Parallel compare of both ports against every valid slot.
always_comb begin
	for (int i = 0; i < arp_pkg::ARP_TABLE_SIZE; i++) begin
		wr_match[i] = valid[i] && (ipv4_mem[i] == wr_ipv4_addr);
		lk_match[i] = valid[i] && (ipv4_mem[i] == lk_ipv4_addr);
	end
end

assign wr_hit = |wr_match;

// Known address rewrites its own slot, a new one claims the slot at the pointer.
always_comb begin
	for (int i = 0; i < arp_pkg::ARP_TABLE_SIZE; i++) begin
		wr_sel[i] = wr_hit ? wr_match[i] : (ins_ptr == arp_pkg::ARP_IDX_W'(i));
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		valid   <= '0;
		ins_ptr <= '0;
	end else if (wr_val && !wr_hit) begin
		valid[ins_ptr] <= 1'b1;
		if (ins_ptr == arp_pkg::ARP_IDX_W'(arp_pkg::ARP_TABLE_SIZE - 1)) begin
			ins_ptr <= '0;
		end else begin
			ins_ptr <= ins_ptr + 1'b1;
		end
	end
end

always_ff @(posedge clk) begin
	for (int i = 0; i < arp_pkg::ARP_TABLE_SIZE; i++) begin
		if (wr_val && wr_sel[i]) begin
			ipv4_mem[i] <= wr_ipv4_addr;
			mac_mem[i]  <= wr_mac_addr;
		end
	end
end

// At most one slot matches, so an OR across the masked entries is the mux.
always_comb begin
	lk_mac_addr = '0;
	for (int i = 0; i < arp_pkg::ARP_TABLE_SIZE; i++) begin
		if (lk_match[i]) begin
			lk_mac_addr = lk_mac_addr | mac_mem[i];
		end
	end
end

assign lk_hit = |lk_match;

// Holds only if no write ever creates a duplicate address.
assert property (@(posedge clk) disable iff (!rst_n) $onehot0(lk_match))
	else $error("arp_entry_store: several slots match the lookup address");

endmodule

// ==== verilog/arp_pkg.sv ====
package arp_pkg;

// Address types carried on the ARP data path.
typedef logic [31:0] ipv4_addr_t;
typedef logic [47:0] mac_addr_t;

// Binding table geometry.
localparam int ARP_TABLE_SIZE = 8;
localparam int ARP_IDX_W      = 3;

// Cycles to wait for a reply before the request is sent again.
localparam int ARP_TIMEOUT_TICKS = 200;

// Requests sent after the first one before giving up.
localparam int ARP_RETRIES = 2;

// Counter widths derived from the limits above.
localparam int ARP_TIMER_W = $clog2(ARP_TIMEOUT_TICKS);
localparam int ARP_RETRY_W = $clog2(ARP_RETRIES + 1);

endpackage
